/* desPkg.sv */
// DES constant tables and the bit permutations built from them, shared by the cipher datapath
package desPkg;

  //////////////////////////////////////////////////////////////
  // Permutation tables, 1-based DES bit numbers, MSB first
  //////////////////////////////////////////////////////////////

  localparam int ipTable [64] = '{
    58, 50, 42, 34, 26, 18, 10,  2, 60, 52, 44, 36, 28, 20, 12,  4,
    62, 54, 46, 38, 30, 22, 14,  6, 64, 56, 48, 40, 32, 24, 16,  8,
    57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
    61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7
  };

  localparam int fpTable [64] = '{
    40,  8, 48, 16, 56, 24, 64, 32, 39,  7, 47, 15, 55, 23, 63, 31,
    38,  6, 46, 14, 54, 22, 62, 30, 37,  5, 45, 13, 53, 21, 61, 29,
    36,  4, 44, 12, 52, 20, 60, 28, 35,  3, 43, 11, 51, 19, 59, 27,
    34,  2, 42, 10, 50, 18, 58, 26, 33,  1, 41,  9, 49, 17, 57, 25
  };

  // Parity bits dropped here
  localparam int pc1Table [56] = '{
    57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
    10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
    14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
  };

  localparam int pc2Table [48] = '{
    14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10, 23, 19, 12,  4,
    26,  8, 16,  7, 27, 20, 13,  2, 41, 52, 31, 37, 47, 55, 30, 40,
    51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
  };

  localparam int eTable [48] = '{
    32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,  8,  9, 10, 11,
    12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
    22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
  };

  localparam int pTable [32] = '{
    16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
     2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
  };

  //////////////////////////////////////////////////////////////
  // S-boxes, indexed by row * 16 + column
  //////////////////////////////////////////////////////////////

  localparam int sBoxTable [8][64] = '{
    '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
       0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
       4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
      15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
    '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
       3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
       0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
      13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
    '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
      13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
      13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
       1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
    '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
      13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
      10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
       3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
    '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
      14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
       4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
      11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
    '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
      10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
       9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
       4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
    '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
      13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
       1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
       6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
    '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
       1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
       7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
       2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
  };

  // DES bit n sits at vector index width - n

  function automatic logic [63:0] initialPerm(input logic [63:0] a);
    logic [63:0] r;
    for (int i = 0; i < 64; i++)
      r[63 - i] = a[64 - ipTable[i]];
    return r;
  endfunction

  function automatic logic [63:0] finalPerm(input logic [63:0] a);
    logic [63:0] r;
    for (int i = 0; i < 64; i++)
      r[63 - i] = a[64 - fpTable[i]];
    return r;
  endfunction

  function automatic logic [55:0] permChoice1(input logic [63:0] a);
    logic [55:0] r;
    for (int i = 0; i < 56; i++)
      r[55 - i] = a[64 - pc1Table[i]];
    return r;
  endfunction

  function automatic logic [47:0] permChoice2(input logic [55:0] a);
    logic [47:0] r;
    for (int i = 0; i < 48; i++)
      r[47 - i] = a[56 - pc2Table[i]];
    return r;
  endfunction

  function automatic logic [47:0] expand(input logic [31:0] a);
    logic [47:0] r;
    for (int i = 0; i < 48; i++)
      r[47 - i] = a[32 - eTable[i]];
    return r;
  endfunction

endpackage

/* tdeaPkg.sv */
// TDEA core widths, block types and FSM, mode and pass encodings used across the core
package tdeaPkg;

  localparam int BlockW        = 64;
  localparam int CdKeyW        = 56;
  localparam int SubkeyW       = 48;
  localparam int HalfW         = 32;
  localparam int RoundsPerPass = 16;

  typedef logic [BlockW-1:0]        blockT;     // Data or raw key
  typedef logic [CdKeyW-1:0]        cdKeyT;     // C in upper half, D in lower
  typedef logic [SubkeyW-1:0]       subkeyT;
  typedef logic [HalfW-1:0]         halfT;
  typedef logic [RoundsPerPass-1:0] roundRingT; // Bit 0 is round 1

  typedef enum logic {
    ModeEnc = 1'b0,
    ModeDec = 1'b1
  } cryptModeT;

  // Also the key slot number
  typedef enum logic [1:0] {
    Pass1 = 2'd0,
    Pass2 = 2'd1,
    Pass3 = 2'd2
  } passT;

  typedef enum logic [2:0] {
    StIdle    = 3'b000,
    StKeyGet1 = 3'b001,
    StKeyGet2 = 3'b010,
    StDes1    = 3'b100,
    StDes2    = 3'b110,
    StDes3    = 3'b111
  } tdeaStateT;

endpackage

/* sBoxLayer.sv */
// DES round function back end: eight S-box lookups then the P permutation, purely combinational
`timescale 1ns/1ns

module sBoxLayer (
  input  tdeaPkg::subkeyT sBoxIn,
  output tdeaPkg::halfT   fOut
);
  import desPkg::*;
  import tdeaPkg::*;

  halfT       sOut;
  logic [5:0] chunk;

  // Outer bits pick the row, inner four the column
  always_comb begin
    chunk = '0;
    sOut  = '0;
    for (int b = 0; b < 8; b++) begin
      chunk = sBoxIn[47 - 6*b -: 6];
      sOut[31 - 4*b -: 4] = 4'(sBoxTable[b][{chunk[5], chunk[0], chunk[4:1]}]);
    end
  end

  always_comb begin
    fOut = '0;
    for (int i = 0; i < 32; i++)
      fOut[31 - i] = sOut[32 - pTable[i]];
  end

endmodule

/* keySchedule.sv */
// TDEA key store and on-the-fly subkey generator, mixes the round subkey into the E output
`timescale 1ns/1ns

module keySchedule (
  input  logic               CLK,
  input  logic               RSTn,
  input  logic               EN,
  input  tdeaPkg::blockT     Kin,
  input  logic               keyLoad,
  input  tdeaPkg::passT      loadSlot,
  input  tdeaPkg::cryptModeT EncDec,
  input  logic               roundEn,
  input  tdeaPkg::passT      pass,
  input  tdeaPkg::roundRingT roundRing,
  input  tdeaPkg::subkeyT    expanded,
  output tdeaPkg::subkeyT    sBoxIn
);
  import desPkg::*;
  import tdeaPkg::*;

  cdKeyT keyReg [3];   // One C/D state per pass
  cdKeyT curKey;
  cdKeyT rotKey;
  logic  toLeft;
  logic  byTwo;

  function automatic cdKeyT rotateCd(input cdKeyT k, input logic left, input logic two);
    logic [27:0] c;
    logic [27:0] d;
    cdKeyT       r;
    c = k[55:28];
    d = k[27:0];
    if (left && two)
      r = {c[25:0], c[27:26], d[25:0], d[27:26]};
    else if (left)
      r = {c[26:0], c[27], d[26:0], d[27]};
    else if (two)
      r = {c[1:0], c[27:2], d[1:0], d[27:2]};
    else
      r = {c[0], c[27:1], d[0], d[27:1]};
    return r;
  endfunction

  //////////////////////////////////////////////////////////////
  // Rotation control
  //////////////////////////////////////////////////////////////

  // Middle pass runs the other direction (E-D-E / D-E-D)
  assign toLeft = (EncDec == ModeEnc) ^ (pass == Pass2);

  // Single-bit rounds differ between forward and reverse order
  assign byTwo = toLeft ? !(roundRing[0] | roundRing[1] | roundRing[8] | roundRing[15])
                        : !(roundRing[0] | roundRing[7] | roundRing[14] | roundRing[15]);

  assign curKey = keyReg[pass];
  assign rotKey = rotateCd(curKey, toLeft, byTwo);

  // Forward uses the shifted key, reverse the one before the shift
  assign sBoxIn = expanded ^ permChoice2(toLeft ? rotKey : curKey);

  always_ff @(posedge CLK) begin
    if (!RSTn) begin
      for (int s = 0; s < 3; s++)
        keyReg[s] <= '0;
    end else if (EN) begin
      if (keyLoad)
        keyReg[loadSlot] <= permChoice1(Kin);
      else if (roundEn)
        keyReg[pass] <= rotKey;   // Back to the loaded value after 16 rounds
    end
  end

  // Loading and running overlap only if the FSM decode is broken
  assert property (@(posedge CLK) disable iff (!RSTn) !(keyLoad && roundEn));

endmodule

/* tdeaControl.sv */
// TDEA sequencer: key load and three-pass FSM, round ring counter and the BSY/Kvld/Dvld strobes
`timescale 1ns/1ns

module tdeaControl (
  input  logic               CLK,
  input  logic               RSTn,
  input  logic               EN,
  input  logic               Krdy,
  input  logic               Drdy,
  input  tdeaPkg::cryptModeT EncDec,
  output logic               keyLoad,
  output tdeaPkg::passT      loadSlot,
  output logic               dataLoad,
  output logic               roundEn,
  output logic               lastRound,
  output tdeaPkg::passT      pass,
  output tdeaPkg::roundRingT roundRing,
  output logic               BSY,
  output logic               Kvld,
  output logic               Dvld
);
  import tdeaPkg::*;

  tdeaStateT state;
  logic      inKeyState;

  assign inKeyState = (state == StIdle) || (state == StKeyGet1) || (state == StKeyGet2);
  assign keyLoad    = inKeyState && Krdy;   // Key wins over data in idle
  assign dataLoad   = (state == StIdle) && Drdy && !Krdy;
  assign roundEn    = state[2];             // All DES states
  assign lastRound  = roundRing[RoundsPerPass-1];
  assign BSY        = (state != StIdle);

  // Decrypt fills the slots in reverse
  always_comb begin
    case (state)
      StKeyGet1: loadSlot = Pass2;
      StKeyGet2: loadSlot = (EncDec == ModeEnc) ? Pass3 : Pass1;
      default:   loadSlot = (EncDec == ModeEnc) ? Pass1 : Pass3;
    endcase
  end

  always_comb begin
    case (state)
      StDes2:  pass = Pass2;
      StDes3:  pass = Pass3;
      default: pass = Pass1;
    endcase
  end

  //////////////////////////////////////////////////////////////
  // FSM and round counter
  //////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (!RSTn) begin
      state     <= StIdle;
      roundRing <= roundRingT'(1);
    end else if (EN) begin
      if (roundEn)
        roundRing <= {roundRing[RoundsPerPass-2:0], roundRing[RoundsPerPass-1]};
      case (state)
        StIdle: begin
          if (Krdy)
            state <= StKeyGet1;
          else if (Drdy)
            state <= StDes1;
        end
        StKeyGet1: if (Krdy) state <= StKeyGet2;
        StKeyGet2: if (Krdy) state <= StIdle;
        StDes1:    if (lastRound) state <= StDes2;
        StDes2:    if (lastRound) state <= StDes3;
        StDes3:    if (lastRound) state <= StIdle;
        default:   state <= StIdle;
      endcase
    end
  end

  // One-cycle strobes
  always_ff @(posedge CLK) begin
    if (!RSTn) begin
      Kvld <= 1'b0;
      Dvld <= 1'b0;
    end else if (EN) begin
      Kvld <= (state == StKeyGet2) && Krdy;
      Dvld <= (state == StDes3) && lastRound;
    end
  end

  assert property (@(posedge CLK) disable iff (!RSTn) $onehot(roundRing));

  // Key loading and a block finishing are separate operations
  assert property (@(posedge CLK) disable iff (!RSTn) !(Kvld && Dvld));

endmodule

/* desDatapath.sv */
// Feistel data register for the iterative TDEA core: IP on load, one round per cycle, FP out
`timescale 1ns/1ns

module desDatapath (
  input  logic            CLK,
  input  logic            RSTn,
  input  logic            EN,
  input  tdeaPkg::blockT  Din,
  input  logic            dataLoad,
  input  logic            roundEn,
  input  logic            lastRound,
  input  tdeaPkg::halfT   fOut,
  output tdeaPkg::subkeyT expanded,
  output tdeaPkg::blockT  Dout
);
  import desPkg::*;
  import tdeaPkg::*;

  blockT dataReg;   // L in upper half, R in lower
  halfT  leftHalf;
  halfT  rightHalf;
  halfT  newRight;

  assign leftHalf  = dataReg[63:32];
  assign rightHalf = dataReg[31:0];
  assign newRight  = leftHalf ^ fOut;

  assign expanded = expand(rightHalf);
  assign Dout     = finalPerm(dataReg);   // Valid once the last pass ends

  always_ff @(posedge CLK) begin
    if (!RSTn) begin
      dataReg <= '0;
    end else if (EN) begin
      if (dataLoad) begin
        dataReg <= initialPerm(Din);
      end else if (roundEn) begin
        // No half swap after round 16 of each pass
        if (lastRound)
          dataReg <= {newRight, rightHalf};
        else
          dataReg <= {rightHalf, newRight};
      end
    end
  end

endmodule

/* tdeaCore.sv */
// Iterative Triple-DES core top: sequencer, key schedule, Feistel datapath and S-box layer
`timescale 1ns/1ns

module tdeaCore (
  input  logic               CLK,
  input  logic               RSTn,
  input  logic               EN,
  input  logic               Krdy,
  input  logic               Drdy,
  input  tdeaPkg::cryptModeT EncDec,
  input  tdeaPkg::blockT     Kin,
  input  tdeaPkg::blockT     Din,
  output tdeaPkg::blockT     Dout,
  output logic               BSY,
  output logic               Kvld,
  output logic               Dvld
);
  import tdeaPkg::*;

  logic      keyLoad;
  passT      loadSlot;
  logic      dataLoad;
  logic      roundEn;
  logic      lastRound;
  passT      pass;
  roundRingT roundRing;
  subkeyT    expanded;   // E(R) from the datapath
  subkeyT    sBoxIn;     // E(R) xor subkey
  halfT      fOut;

  tdeaControl ctrl0 (
    .CLK, .RSTn, .EN, .Krdy, .Drdy, .EncDec,
    .keyLoad, .loadSlot, .dataLoad, .roundEn, .lastRound,
    .pass, .roundRing, .BSY, .Kvld, .Dvld
  );

  keySchedule keys0 (
    .CLK, .RSTn, .EN, .Kin, .keyLoad, .loadSlot, .EncDec,
    .roundEn, .pass, .roundRing, .expanded, .sBoxIn
  );

  desDatapath data0 (
    .CLK, .RSTn, .EN, .Din, .dataLoad, .roundEn, .lastRound,
    .fOut, .expanded, .Dout
  );

  sBoxLayer sbox0 (
    .sBoxIn,
    .fOut
  );

endmodule

/* tdeaTbTasks.svh */
// Drive, compare and directed test tasks included into the TDEA core testbench module

  //////////////////////////////////////////////////////////////
  // Drive and compare helpers
  //////////////////////////////////////////////////////////////

  task automatic nextCycle();
    @(posedge CLK);
    #1;   // Inputs change just after the edge
  endtask

  function automatic blockT randomBlock();
    return {$urandom, $urandom};
  endfunction

  task automatic compareBlock(input string name, input blockT got, input blockT exp);
    if (got !== exp)
      failRun($sformatf("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic compareBit(input string name, input logic got, input logic exp);
    if (got !== exp)
      failRun($sformatf("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp));
  endtask

  task automatic compareCount(input string name, input int got, input int exp);
    if (got != exp)
      failRun($sformatf("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp));
  endtask

  // Kvld pulses in the cycle after the third key
  task automatic loadKeys(input cryptModeT mode, input blockT k1, input blockT k2,
                          input blockT k3);
    blockT keys [3];
    keys   = '{k1, k2, k3};
    EncDec = mode;
    Krdy   = 1'b1;
    for (int i = 0; i < 3; i++) begin
      Kin = keys[i];
      nextCycle();
      compareBit("Kvld", Kvld, i == 2);
      compareBit("BSY", BSY, i < 2);
    end
    Krdy = 1'b0;
    nextCycle();
    compareBit("Kvld", Kvld, 1'b0);
  endtask

  // Optional EN stall and a stray Drdy while busy, both counted from the Drdy drive
  task automatic runBlock(input blockT din, input int stallAt, input int stallLen,
                          input int intrudeAt, input blockT intrudeDin,
                          output blockT dout, output int latency);
    Din  = din;
    Drdy = 1'b1;
    nextCycle();
    Drdy    = 1'b0;
    latency = 1;
    while (!Dvld) begin
      compareBit("BSY", BSY, 1'b1);
      Drdy = (latency == intrudeAt);
      if (latency == intrudeAt)
        Din = intrudeDin;
      if (latency == stallAt)
        EN = 1'b0;
      if (latency == stallAt + stallLen)
        EN = 1'b1;
      nextCycle();
      latency++;
    end
    compareBit("BSY", BSY, 1'b0);
    dout = Dout;
    nextCycle();
    compareBit("Dvld", Dvld, 1'b0);   // Single-cycle pulse
    compareBlock("Dout", Dout, dout);
  endtask

  //////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////

  task automatic checkResetState();
    compareBit("BSY", BSY, 1'b0);
    compareBit("Kvld", Kvld, 1'b0);
    compareBit("Dvld", Dvld, 1'b0);
  endtask

  // Equal keys reduce TDEA to single DES
  task automatic knownAnswerTest();
    blockT res;
    int    lat;
    loadKeys(ModeEnc, KatKey, KatKey, KatKey);
    runBlock(KatPlain, 0, 0, 0, '0, res, lat);
    compareBlock("Dout", res, KatCipher);
    loadKeys(ModeDec, KatKey, KatKey, KatKey);
    runBlock(KatCipher, 0, 0, 0, '0, res, lat);
    compareBlock("Dout", res, KatPlain);
  endtask

  task automatic roundTripTest();
    blockT k [3];
    blockT plain [10];
    blockT cipher [10];
    blockT res;
    int    lat;
    k[0] = randomBlock();
    do
      k[1] = randomBlock();
    while (k[1] == k[0]);
    do
      k[2] = randomBlock();
    while (k[2] == k[0] || k[2] == k[1]);
    loadKeys(ModeEnc, k[0], k[1], k[2]);
    foreach (plain[i]) begin
      plain[i] = randomBlock();
      runBlock(plain[i], 0, 0, 0, '0, cipher[i], lat);
      compareCount("Dvld latency", lat, BlockLatency);
    end
    loadKeys(ModeDec, k[0], k[1], k[2]);
    foreach (cipher[i]) begin
      runBlock(cipher[i], 0, 0, 0, '0, res, lat);
      compareBlock("Dout", res, plain[i]);
    end
  endtask

  // Stray Drdy with another block in round 10
  task automatic timingTest();
    blockT res;
    int    lat;
    loadKeys(ModeEnc, KatKey, KatKey, KatKey);
    runBlock(KatPlain, 0, 0, 10, randomBlock(), res, lat);
    compareCount("Dvld latency", lat, BlockLatency);
    compareBlock("Dout", res, KatCipher);
  endtask

  task automatic stallTest();
    blockT res;
    int    lat;
    int    stall;
    stall = 1 + int'($urandom % 10);
    runBlock(KatPlain, 20, stall, 0, '0, res, lat);
    compareCount("Dvld latency", lat, BlockLatency + stall);
    compareBlock("Dout", res, KatCipher);
  endtask

/* tdeaTb.sv */
// Self-checking testbench for the TDEA core with clock, reset, timeout and the directed tests
`timescale 1ns/1ns

module tdeaTb;
  import tdeaPkg::*;

  localparam int    ResetCycles  = 8;
  localparam int    BlockLatency = 49;        // Drdy drive to Dvld, in clock edges
  localparam int    OpCycles     = 60;        // One key load or block with slack
  localparam int    MaxCycles    = 50 * OpCycles;
  localparam blockT KatKey       = 64'h1334_5779_9BBC_DFF1;
  localparam blockT KatPlain     = 64'h0123_4567_89AB_CDEF;
  localparam blockT KatCipher    = 64'h85E8_1354_0F0A_B405;

  logic      CLK;
  logic      RSTn;
  logic      EN;
  logic      Krdy;
  logic      Drdy;
  cryptModeT EncDec;
  blockT     Kin;
  blockT     Din;
  blockT     Dout;
  logic      BSY;
  logic      Kvld;
  logic      Dvld;

  int cycleCount = 0;

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  `include "tdeaTbTasks.svh"

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;   // 8 ns period
  end

  tdeaCore dut0 (
    .CLK, .RSTn, .EN, .Krdy, .Drdy, .EncDec, .Kin, .Din,
    .Dout, .BSY, .Kvld, .Dvld
  );

  //////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    cycleCount++;
    if (cycleCount >= MaxCycles)
      failRun("Timeout, the DUT did not finish the tests in time");
  end

  //////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hf84c));
    RSTn   = 1'b0;
    EN     = 1'b1;
    Krdy   = 1'b0;
    Drdy   = 1'b0;
    EncDec = ModeEnc;
    Kin    = '0;
    Din    = '0;
    repeat (ResetCycles) @(posedge CLK);
    #1;
    RSTn = 1'b1;

    checkResetState();
    knownAnswerTest();
    roundTripTest();
    timingTest();
    stallTest();

    $display("Everything OK");
    $finish;
  end

endmodule

/* flist.f */
+incdir+.
desPkg.sv
tdeaPkg.sv
sBoxLayer.sv
keySchedule.sv
tdeaControl.sv
desDatapath.sv
tdeaCore.sv
tdeaTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tdeaTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST)) tdeaTbTasks.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
